/* rtl/dot_pkg.sv */
package dot_pkg;

  // element and vector sizes
  localparam int data_w     = 8;
  localparam int chunk_len  = 9;
  localparam int vec_len    = 36;
  localparam int num_chunks = vec_len / chunk_len;
  localparam int num_rows   = 4;
  localparam int num_outs   = 4;
  localparam int num_layers = 2;

  // one ROM word per (layer, output, chunk)
  localparam int rom_depth  = num_layers * num_outs * num_chunks;
  localparam int rom_aw     = 5;

  // rom read plus three inner product stages
  localparam int pipe_lat   = 4;
  localparam int acc_w      = 24;

  typedef logic signed [data_w-1:0] data_t;

  // element 0 sits in the low byte
  typedef logic [chunk_len*data_w-1:0] chunk_t;

  // 16-bit products, nine of them
  typedef logic signed [2*data_w+$clog2(chunk_len)-1:0] prod_sum_t;

  typedef logic signed [acc_w-1:0] result_t;

  typedef logic [rom_aw-1:0] rom_addr_t;
  typedef logic [$clog2(num_chunks)-1:0] chunk_idx_t;
  typedef logic [$clog2(num_outs)-1:0] out_idx_t;
  typedef logic layer_t;

  typedef enum logic [1:0] {
    idle,
    fetch,
    drain,
    done
  } ctrl_state_t;

endpackage

/* rtl/dot_ctrl_if.sv */
interface dot_ctrl_if import dot_pkg::*; ();

  chunk_idx_t chunk_sel;
  logic       capture;

  // aligned with the inner product output
  logic       acc_first;
  logic       acc_store;
  out_idx_t   out_sel;

  modport ctrl (
    output chunk_sel,
    output capture,
    output acc_first,
    output acc_store,
    output out_sel
  );

  modport lane (
    input chunk_sel,
    input capture,
    input acc_first,
    input acc_store,
    input out_sel
  );

endinterface

/* rtl/dot_ctrl.sv */
module dot_ctrl import dot_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      load,
  input  layer_t    layer,
  output rom_addr_t rom_addr,
  output logic      valid,
  dot_ctrl_if.ctrl  ctl
);

  ctrl_state_t state;
  chunk_idx_t  chunk_cnt;
  out_idx_t    out_cnt;
  logic [$clog2(pipe_lat+1)-1:0] drain_cnt;

  logic issue;
  logic last_issue;
  logic issue_first;
  logic issue_last;

  // capture-time flags, pipe_lat deep
  logic [pipe_lat-1:0] first_dly;
  logic [pipe_lat-1:0] store_dly;
  out_idx_t            out_dly [pipe_lat];

  // idle with load high is cycle 0, counters are already zero
  assign issue       = load && (state == idle || state == fetch);
  assign issue_first = issue && (chunk_cnt == '0);
  assign issue_last  = issue && (chunk_cnt == chunk_idx_t'(num_chunks - 1));
  assign last_issue  = issue_last && (out_cnt == out_idx_t'(num_outs - 1));

  // layer x 16 + output x 4 + chunk
  assign rom_addr = {layer, out_cnt, chunk_cnt};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= idle;
      chunk_cnt <= '0;
      out_cnt   <= '0;
      drain_cnt <= '0;
      valid     <= 1'b0;
    end else if (!load) begin
      // abort or end of transfer
      state     <= idle;
      chunk_cnt <= '0;
      out_cnt   <= '0;
      drain_cnt <= '0;
      valid     <= 1'b0;
    end else begin
      valid <= (state == done);
      if (issue) begin
        {out_cnt, chunk_cnt} <= {out_cnt, chunk_cnt} + 1'b1;
      end
      case (state)
        idle: begin
          state <= fetch;
        end
        fetch: begin
          if (last_issue) begin
            state     <= drain;
            drain_cnt <= '0;
          end
        end
        drain: begin
          // wait for the last store to land
          if (drain_cnt == pipe_lat) begin
            state <= done;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        default: begin
          state <= done;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_dly <= '0;
      store_dly <= '0;
    end else if (!load) begin
      // no partial store after an abort
      first_dly <= '0;
      store_dly <= '0;
    end else begin
      first_dly <= {first_dly[pipe_lat-2:0], issue_first};
      store_dly <= {store_dly[pipe_lat-2:0], issue_last};
    end
  end

  always_ff @(posedge clk) begin
    out_dly[0] <= out_cnt;
    for (int i = 1; i < pipe_lat; i++) begin
      out_dly[i] <= out_dly[i-1];
    end
  end

  assign ctl.chunk_sel = chunk_cnt;
  assign ctl.capture   = issue;
  assign ctl.acc_first = first_dly[pipe_lat-1];
  assign ctl.acc_store = store_dly[pipe_lat-1];
  assign ctl.out_sel   = out_dly[pipe_lat-1];

endmodule

/* rtl/weight_rom.sv */
module weight_rom import dot_pkg::*; (
  input  logic      clk,
  input  rom_addr_t addr,
  output chunk_t    word
);

  chunk_t mem [rom_depth];

  // word w of the image is address w
  initial begin
    $readmemh("rtl/weights.mem", mem);
  end

  // registered read, one cycle of latency
  always_ff @(posedge clk) begin
    word <= mem[addr];
  end

endmodule

/* rtl/inner_product.sv */
module inner_product import dot_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  chunk_t    a,
  input  chunk_t    b,
  output prod_sum_t sum
);

  data_t a_el [chunk_len];
  data_t b_el [chunk_len];

  logic signed [2*data_w-1:0] prod [chunk_len];
  logic signed [2*data_w+1:0] part [chunk_len/3];

  always_comb begin
    for (int i = 0; i < chunk_len; i++) begin
      a_el[i] = a[i*data_w +: data_w];
      b_el[i] = b[i*data_w +: data_w];
    end
  end

  // stage one, products
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < chunk_len; i++) begin
        prod[i] <= '0;
      end
    end else begin
      for (int i = 0; i < chunk_len; i++) begin
        prod[i] <= a_el[i] * b_el[i];
      end
    end
  end

  // stage two, groups of three
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int j = 0; j < chunk_len / 3; j++) begin
        part[j] <= '0;
      end
    end else begin
      for (int j = 0; j < chunk_len / 3; j++) begin
        part[j] <= prod[3*j] + prod[3*j+1] + prod[3*j+2];
      end
    end
  end

  // stage three
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum <= '0;
    end else begin
      sum <= part[0] + part[1] + part[2];
    end
  end

endmodule

/* rtl/row_lane.sv */
module row_lane import dot_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [vec_len*data_w-1:0] row,
  input  chunk_t                    weights,
  dot_ctrl_if.lane                  ctl,
  output logic [num_outs*acc_w-1:0] results
);

  chunk_t    chunk_q;
  prod_sum_t sum;
  result_t   acc;
  result_t   acc_next;
  result_t   res_q [num_outs];

  // selected nine elements, zero when idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      chunk_q <= '0;
    end else if (ctl.capture) begin
      chunk_q <= row[ctl.chunk_sel*chunk_len*data_w +: chunk_len*data_w];
    end else begin
      chunk_q <= '0;
    end
  end

  inner_product u_inner_product (
    .clk   (clk),
    .rst_n (rst_n),
    .a     (chunk_q),
    .b     (weights),
    .sum   (sum)
  );

  // first chunk of an output restarts the sum
  assign acc_next = ctl.acc_first ? result_t'(sum) : acc + sum;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
    end else begin
      acc <= acc_next;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int m = 0; m < num_outs; m++) begin
        res_q[m] <= '0;
      end
    end else if (ctl.acc_store) begin
      res_q[ctl.out_sel] <= acc_next;
    end
  end

  always_comb begin
    for (int m = 0; m < num_outs; m++) begin
      results[m*acc_w +: acc_w] = res_q[m];
    end
  end

endmodule

/* rtl/dot_top.sv */
module dot_top import dot_pkg::*; (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               load,
  input  layer_t                             layer,
  input  logic [num_rows*vec_len*data_w-1:0] d,
  output logic                               valid,
  output logic [num_rows*num_outs*acc_w-1:0] q
);

  rom_addr_t rom_addr;
  chunk_t    rom_word;

  dot_ctrl_if ctl_if ();

  dot_ctrl u_dot_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (load),
    .layer    (layer),
    .rom_addr (rom_addr),
    .valid    (valid),
    .ctl      (ctl_if.ctrl)
  );

  // one word feeds every lane
  weight_rom u_weight_rom (
    .clk  (clk),
    .addr (rom_addr),
    .word (rom_word)
  );

  for (genvar r = 0; r < num_rows; r++) begin : g_lane
    row_lane u_row_lane (
      .clk     (clk),
      .rst_n   (rst_n),
      .row     (d[r*vec_len*data_w +: vec_len*data_w]),
      .weights (rom_word),
      .ctl     (ctl_if.lane),
      .results (q[r*num_outs*acc_w +: num_outs*acc_w])
    );
  end

endmodule

/* bench/dot_tb.sv */
module dot_tb import dot_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int d_w        = num_rows * vec_len * data_w;
  localparam int q_w        = num_rows * num_outs * acc_w;
  localparam int num_slots  = num_rows * num_outs;
  localparam int valid_edge = 21;
  localparam int num_tests  = 10;

  typedef enum int {
    pat_lfsr,
    pat_prev,
    pat_max,
    pat_min,
    pat_alt,
    pat_zero
  } pattern_t;

  typedef struct {
    string    name;
    layer_t   layer;
    pattern_t pattern;
    int       load_len;
    int       idle_len;
  } entry_t;

  // idle_len counts the edges with load low before the entry starts
  entry_t tests [num_tests] = '{
    '{"lfsr_layer0",   1'b0, pat_lfsr, 24, 1},
    '{"same_layer1",   1'b1, pat_prev, 24, 2},
    '{"all_max",       1'b0, pat_max,  24, 1},
    '{"all_min",       1'b1, pat_min,  24, 1},
    '{"alt_sign",      1'b0, pat_alt,  24, 3},
    '{"abort_early",   1'b1, pat_lfsr, 8,  1},
    '{"after_abort",   1'b1, pat_lfsr, 24, 1},
    '{"zero_vec",      1'b0, pat_zero, 24, 1},
    '{"back_to_back",  1'b1, pat_lfsr, 24, 1},
    '{"lfsr_tail",     1'b0, pat_lfsr, 24, 4}
  };

  logic           clk = 1'b0;
  logic           rst_n;
  logic           load;
  layer_t         layer;
  logic [d_w-1:0] d;
  logic           valid;
  logic [q_w-1:0] q;

  chunk_t         wmem [rom_depth];
  logic [15:0]    lfsr_state;
  logic [d_w-1:0] stim_d;
  longint         exp_q [num_slots];
  int             cycle_cnt = 0;
  int             cycle_limit = 1000000;

  dot_top u_dot_top (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .layer (layer),
    .d     (d),
    .valid (valid),
    .q     (q)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  function automatic int limit_for_table();
    int total;
    total = 50;
    for (int i = 0; i < num_tests; i++) begin
      total += tests[i].load_len + 10;
    end
    return total;
  endfunction

  // galois form, taps 16,14,13,11
  function automatic logic [7:0] random_byte();
    logic out_bit;
    for (int b = 0; b < 8; b++) begin
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
        lfsr_state = lfsr_state ^ 16'hb400;
      end
      random_byte[b] = out_bit;
    end
  endfunction

  task automatic build_activations(input pattern_t pattern);
    logic [7:0] value;
    int         idx;
    if (pattern != pat_prev) begin
      for (int r = 0; r < num_rows; r++) begin
        for (int e = 0; e < vec_len; e++) begin
          idx = r * vec_len + e;
          case (pattern)
            pat_lfsr: value = random_byte();
            pat_max:  value = 8'h7f;
            pat_min:  value = 8'h80;
            pat_alt:  value = ((r + e) % 2 == 0) ? 8'h7f : 8'h80;
            default:  value = 8'h00;
          endcase
          stim_d[idx*data_w +: data_w] = value;
        end
      end
    end
  endtask

  // q(r, m) = sum over e of d(r, e) * w(layer*16 + m*4 + e/9)[e%9]
  task automatic compute_expected(input layer_t lay);
    longint acc;
    longint act;
    longint wt;
    int     addr;
    for (int r = 0; r < num_rows; r++) begin
      for (int m = 0; m < num_outs; m++) begin
        acc = 0;
        for (int e = 0; e < vec_len; e++) begin
          addr = lay * 16 + m * 4 + e / chunk_len;
          act  = longint'($signed(stim_d[(r*vec_len+e)*data_w +: data_w]));
          wt   = longint'($signed(wmem[addr][(e%chunk_len)*data_w +: data_w]));
          acc += act * wt;
        end
        exp_q[r*num_outs+m] = acc;
      end
    end
  endtask

  task automatic check_value(input string what, input logic signed [63:0] expected,
                             input logic signed [63:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %0d, actual %0d", what, expected, actual);
      $display("TB FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic check_results(input string name);
    for (int s = 0; s < num_slots; s++) begin
      check_value($sformatf("%s q row %0d out %0d", name, s / num_outs, s % num_outs),
                  exp_q[s], $signed(q[s*acc_w +: acc_w]));
    end
  endtask

  task automatic apply_entry(input int i);
    string name;
    name = tests[i].name;
    build_activations(tests[i].pattern);
    compute_expected(tests[i].layer);
    repeat (tests[i].idle_len - 1) @(posedge clk);
    @(posedge clk);
    load  <= 1'b1;
    layer <= tests[i].layer;
    d     <= stim_d;
    @(negedge clk);
    check_value({name, " valid while idle"}, 0, valid);
    // edge k is the k-th rising edge after load is first sampled high
    for (int k = 0; k < tests[i].load_len; k++) begin
      @(posedge clk);
      if (k == tests[i].load_len - 1) begin
        load <= 1'b0;
      end
      @(negedge clk);
      check_value($sformatf("%s valid at edge %0d", name, k), k >= valid_edge, valid);
      if (k >= valid_edge && (k == valid_edge || k == tests[i].load_len - 1)) begin
        check_results(name);
      end
    end
  endtask

  initial begin
    rst_n = 1'b0;
    load  = 1'b0;
    layer = 1'b0;
    d     = '0;
    stim_d = '0;
    lfsr_state = 16'd17449;
    cycle_limit = limit_for_table();
    $readmemh("rtl/weights.mem", wmem);
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("reset valid", 0, valid);
    for (int i = 0; i < num_tests; i++) begin
      apply_entry(i);
    end
    @(posedge clk);
    @(negedge clk);
    check_value("final valid after load drop", 0, valid);
    $display("TB PASSED");
    $finish;
  end

endmodule

/* rtl/weights.mem */
// one 72-bit word per line, element 8 in the high byte and element 0 in the low byte
7f7f7f7f7f7f7f7f7f
7f7f7f7f7f7f7f7f7f
7f7f7f7f7f7f7f7f7f
7f7f7f7f7f7f7f7f7f
808080808080808080
808080808080808080
808080808080808080
808080808080808080
3cf1079a22e5400bc8
057f8013ee612df89c
b41966d003fe728a41
e72b905c11cd38f406
7a04c3e95817a63f81
12d94e80b76cf02593
ff016ac5398e54d720
48b21d77e00a9f63cc
808080808080808080
808080808080808080
808080808080808080
808080808080808080
010203040506070809
f7f8f9fafbfcfdfeff
6e9127dc4ab50873ae
33cc55aa0ff069967f
a15b2ee27c8619d340
0d64bf3891fa4c27e5
883ad10e6fc2951b74
5ea702f936cb806d19
c9127e45e308b15a2f
24dd836b1097fc3ea8
710ce629d453be0792
9d461fb862ea35c00b

/* all.f */
rtl/dot_pkg.sv
rtl/dot_ctrl_if.sv
rtl/dot_ctrl.sv
rtl/weight_rom.sv
rtl/inner_product.sv
rtl/row_lane.sv
rtl/dot_top.sv
bench/dot_tb.sv

/* Bender.yml */
package:
  name: dot_engine

sources:
  - rtl/dot_pkg.sv
  - rtl/dot_ctrl_if.sv
  - rtl/dot_ctrl.sv
  - rtl/weight_rom.sv
  - rtl/inner_product.sv
  - rtl/row_lane.sv
  - rtl/dot_top.sv
  - target: test
    files:
      - bench/dot_tb.sv
